// File: stq_consts.svh
// store queue sizing; depth must stay a power of two matching STQ_IDX_W, accesses naturally aligned
`ifndef STQ_CONSTS_SVH
`define STQ_CONSTS_SVH

// queue geometry
`define STQ_DEPTH 16
`define STQ_IDX_W 4

// datapath widths
`define STQ_ADDR_W 32
`define STQ_DATA_W 32
`define STQ_BE_W 4

// access size codes, code 3 decodes as a word
`define STQ_SZ_BYTE 2'd0
`define STQ_SZ_HALF 2'd1
`define STQ_SZ_WORD 2'd2

`endif

// File: stq_pkg.sv
// shared store queue types; widths come from stq_consts.svh and are not meant to be overridden
package stq_pkg;

  `include "stq_consts.svh"

  typedef logic [`STQ_IDX_W-1:0] stq_idx_t;   // queue entry index
  typedef logic [`STQ_ADDR_W-1:0] stq_addr_t; // byte address

  // word address, byte address without the lane offset
  typedef logic [`STQ_ADDR_W-$clog2(`STQ_BE_W)-1:0] stq_waddr_t;

  typedef logic [`STQ_DATA_W-1:0] stq_data_t;
  typedef logic [`STQ_BE_W-1:0] stq_be_t;      // one bit per byte lane
  typedef logic [1:0] stq_size_t;
  typedef logic [$clog2(`STQ_BE_W)-1:0] stq_ofs_t;

  // outcome of a load check against the queue
  typedef enum logic [1:0] {
    FWD_MISS,
    FWD_HIT,
    FWD_CONFLICT
  } stq_fwd_e;

endpackage

// File: stq_if.sv
// internal stage links of the store queue; lookup has no ready since execute always takes it
`timescale 1ns/1ps

// registered load lookup, decode to execute
interface stq_lookup_if import stq_pkg::*;;
  logic valid;
  stq_waddr_t waddr;
  stq_be_t be;
  stq_ofs_t ofs;

  modport src (
    output valid,
    output waddr,
    output be,
    output ofs
  );

  modport dst (
    input valid,
    input waddr,
    input be,
    input ofs
  );
endinterface

// youngest overlapping store, execute to result
interface stq_fwd_if import stq_pkg::*;;
  logic valid;
  logic match;         // any overlapping store found
  stq_be_t st_be;
  logic st_data_valid;
  stq_data_t st_data;
  stq_be_t ld_be;
  stq_ofs_t ld_ofs;

  modport src (
    output valid, match, st_be, st_data_valid, st_data,
    output ld_be, ld_ofs
  );

  modport dst (
    input valid, match, st_be, st_data_valid, st_data,
    input ld_be, ld_ofs
  );
endinterface

// File: stq_decode.sv
// address decode stage; addresses must be aligned to their size, misaligned lanes are not detected
`timescale 1ns/1ps

`include "stq_consts.svh"

module stq_decode import stq_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       st_valid,
  input  stq_addr_t  st_addr,
  input  stq_size_t  st_size,
  input  logic       ld_valid,
  input  stq_addr_t  ld_addr,
  input  stq_size_t  ld_size,
  input  logic       advance,
  output stq_waddr_t st_waddr,
  output stq_be_t    st_be,
  output logic       ld_ready,
  stq_lookup_if.src  lookup
);

  logic       lk_valid;
  stq_waddr_t lk_waddr;
  stq_be_t    lk_be;
  stq_ofs_t   lk_ofs;
  stq_ofs_t   st_ofs;
  stq_ofs_t   ld_ofs;

  // byte lanes touched by an aligned access
  function automatic stq_be_t size_mask(stq_size_t size, stq_ofs_t ofs);
    stq_be_t base;
    case (size)
      `STQ_SZ_BYTE: base = 4'b0001;
      `STQ_SZ_HALF: base = 4'b0011;
      default:      base = 4'b1111; // word and code 3
    endcase
    return base << ofs;
  endfunction

  assign st_ofs   = st_addr[$bits(stq_ofs_t)-1:0];
  assign ld_ofs   = ld_addr[$bits(stq_ofs_t)-1:0];
  assign st_waddr = st_addr[`STQ_ADDR_W-1:$bits(stq_ofs_t)];
  assign st_be    = size_mask(st_size, st_ofs) & {`STQ_BE_W{st_valid}};

  always_ff @(posedge clk) begin
    if (rst) begin
      lk_valid <= 1'b0;
    end else if (advance) begin
      lk_valid <= ld_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance && ld_valid) begin
      lk_waddr <= ld_addr[`STQ_ADDR_W-1:$bits(stq_ofs_t)];
      lk_be    <= size_mask(ld_size, ld_ofs);
      lk_ofs   <= ld_ofs; // kept for result alignment
    end
  end

  assign lookup.valid = lk_valid;
  assign lookup.waddr = lk_waddr;
  assign lookup.be    = lk_be;
  assign lookup.ofs   = lk_ofs;

  assign ld_ready = advance;

endmodule

// File: stq_execute.sv
// entry array and pointers; upd_idx to a free entry is dropped, search sees pre-edge state
`timescale 1ns/1ps

`include "stq_consts.svh"

module stq_execute import stq_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       st_valid,
  input  stq_waddr_t st_waddr,
  input  stq_be_t    st_be,
  input  logic       upd_en,
  input  stq_idx_t   upd_idx,
  input  stq_data_t  upd_data,
  input  logic       drain_ready,
  stq_lookup_if.dst  lookup,
  output logic       st_ready,
  output logic       drain_valid,
  output stq_addr_t  drain_addr,
  output stq_be_t    drain_be,
  output stq_data_t  drain_data,
  stq_fwd_if.src     fwd
);

  logic [`STQ_DEPTH-1:0] ent_valid;
  logic [`STQ_DEPTH-1:0] ent_dv;     // data has arrived
  stq_waddr_t            ent_waddr [`STQ_DEPTH];
  stq_be_t               ent_be    [`STQ_DEPTH];
  stq_data_t             ent_data  [`STQ_DEPTH];

  stq_idx_t             head;
  stq_idx_t             tail;
  logic [`STQ_IDX_W:0]  count;

  logic                  alloc;
  logic                  upd_fire;
  logic                  drain_fire;
  logic [`STQ_DEPTH-1:0] hit;
  logic                  found;
  stq_idx_t              sel;

  assign st_ready   = (count != `STQ_DEPTH);
  assign alloc      = st_valid && st_ready;
  assign upd_fire   = upd_en && ent_valid[upd_idx];
  assign drain_valid = ent_valid[head] && ent_dv[head];
  assign drain_fire = drain_valid && drain_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      ent_valid <= '0;
      ent_dv    <= '0;
      head      <= '0;
      tail      <= '0;
      count     <= '0;
    end else begin
      if (upd_fire) begin
        ent_dv[upd_idx] <= 1'b1;
      end
      if (alloc) begin
        ent_valid[tail] <= 1'b1;
        ent_dv[tail]    <= 1'b0;
        tail            <= tail + 1'b1;
      end
      if (drain_fire) begin
        ent_valid[head] <= 1'b0; // head leaves for the cache
        head            <= head + 1'b1;
      end
      case ({alloc, drain_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (alloc) begin
      ent_waddr[tail] <= st_waddr;
      ent_be[tail]    <= st_be;
    end
    if (upd_fire) begin
      ent_data[upd_idx] <= upd_data; // producer already lane-aligned
    end
  end

  // same word and at least one shared byte lane
  always_comb begin
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      hit[i] = ent_valid[i] && (ent_waddr[i] == lookup.waddr) &&
               |(ent_be[i] & lookup.be);
    end
  end

  // walk from oldest to youngest, last hit wins
  always_comb begin
    stq_idx_t idx;
    found = 1'b0;
    sel   = head;
    for (int k = 0; k < `STQ_DEPTH; k++) begin
      idx = head + stq_idx_t'(k);
      if (hit[idx]) begin
        found = 1'b1;
        sel   = idx;
      end
    end
  end

  assign fwd.valid         = lookup.valid;
  assign fwd.match         = found;
  assign fwd.st_be         = ent_be[sel];
  assign fwd.st_data_valid = ent_dv[sel];
  assign fwd.st_data       = ent_data[sel];
  assign fwd.ld_be         = lookup.be;
  assign fwd.ld_ofs        = lookup.ofs;

  assign drain_addr = {ent_waddr[head], {$bits(stq_ofs_t){1'b0}}};
  assign drain_be   = ent_be[head];
  assign drain_data = ent_data[head];

endmodule

// File: stq_result.sv
// response stage; resp_kind and resp_data are only meaningful while resp_valid is high
`timescale 1ns/1ps

`include "stq_consts.svh"

module stq_result import stq_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      resp_ready,
  stq_fwd_if.dst    fwd,
  output logic      advance,
  output logic      resp_valid,
  output stq_fwd_e  resp_kind,
  output stq_data_t resp_data
);

  stq_fwd_e  kind;
  stq_data_t data;

  assign advance = !resp_valid || resp_ready;

  always_comb begin
    kind = FWD_MISS;
    if (fwd.match) begin
      // full cover with data present, anything else must wait
      if (((fwd.st_be & fwd.ld_be) == fwd.ld_be) && fwd.st_data_valid) begin
        kind = FWD_HIT;
      end else begin
        kind = FWD_CONFLICT;
      end
    end
  end

  always_comb begin
    stq_data_t shifted;
    stq_be_t   lanes;
    shifted = fwd.st_data >> {fwd.ld_ofs, 3'b000};
    lanes   = fwd.ld_be >> fwd.ld_ofs;
    data    = '0;
    for (int b = 0; b < `STQ_BE_W; b++) begin
      if (lanes[b]) begin
        data[8*b +: 8] = shifted[8*b +: 8];
      end
    end
    if (kind != FWD_HIT) begin
      data = '0; // no data on miss or conflict
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid <= 1'b0;
    end else if (advance) begin
      resp_valid <= fwd.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance && fwd.valid) begin
      resp_kind <= kind;
      resp_data <= data;
    end
  end

endmodule

// File: stq_top.sv
// 16-entry store queue; accesses must be naturally aligned and upd_data lane-placed by the producer
`timescale 1ns/1ps

module stq_top import stq_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  // store address
  input  logic      st_valid,
  output logic      st_ready,
  input  stq_addr_t st_addr,
  input  stq_size_t st_size,
  // store data
  input  logic      upd_en,
  input  stq_idx_t  upd_idx,
  input  stq_data_t upd_data,
  // load check
  input  logic      ld_valid,
  output logic      ld_ready,
  input  stq_addr_t ld_addr,
  input  stq_size_t ld_size,
  // load response
  output logic      resp_valid,
  input  logic      resp_ready,
  output stq_fwd_e  resp_kind,
  output stq_data_t resp_data,
  // drain to cache
  output logic      drain_valid,
  input  logic      drain_ready,
  output stq_addr_t drain_addr,
  output stq_be_t   drain_be,
  output stq_data_t drain_data
);

  stq_waddr_t st_waddr;
  stq_be_t    st_be;
  logic       advance;

  stq_lookup_if lookup_if ();
  stq_fwd_if    fwd_if ();

  stq_decode u_decode (
    .clk, .rst,
    .st_valid, .st_addr, .st_size,
    .ld_valid, .ld_addr, .ld_size,
    .advance,
    .st_waddr, .st_be,
    .ld_ready,
    .lookup (lookup_if.src)
  );

  stq_execute u_execute (
    .clk, .rst,
    .st_valid, .st_waddr, .st_be,
    .upd_en, .upd_idx, .upd_data,
    .drain_ready,
    .lookup (lookup_if.dst),
    .st_ready,
    .drain_valid, .drain_addr, .drain_be, .drain_data,
    .fwd    (fwd_if.src)
  );

  stq_result u_result (
    .clk, .rst,
    .resp_ready,
    .fwd (fwd_if.dst),
    .advance,
    .resp_valid, .resp_kind, .resp_data
  );

endmodule

// File: tb_stq_asserts.sv
// protocol checks bound into stq_top; outstanding count assumes no store allocates while reset is high
`timescale 1ns/1ps

`include "stq_consts.svh"

module tb_stq_asserts import stq_pkg::*; (
  input logic      clk,
  input logic      rst,
  input logic      st_valid,
  input logic      st_ready,
  input stq_addr_t st_addr,
  input stq_size_t st_size,
  input logic      resp_valid,
  input logic      resp_ready,
  input stq_fwd_e  resp_kind,
  input stq_data_t resp_data,
  input logic      drain_valid,
  input logic      drain_ready,
  input stq_addr_t drain_addr,
  input stq_be_t   drain_be,
  input stq_data_t drain_data
);

  logic [`STQ_IDX_W:0] outstanding;

  always_ff @(posedge clk) begin
    if (rst) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + (st_valid && st_ready) - (drain_valid && drain_ready);
    end
  end

  a_resp_hold: assert property (@(posedge clk) disable iff (rst)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_kind) && $stable(resp_data))
    else $error("load response changed while stalled");

  a_drain_hold: assert property (@(posedge clk) disable iff (rst)
    drain_valid && !drain_ready |=> drain_valid && $stable(drain_addr) &&
      $stable(drain_be) && $stable(drain_data))
    else $error("drain payload dropped before transfer");

  a_full: assert property (@(posedge clk) disable iff (rst)
    outstanding == `STQ_DEPTH |-> !st_ready)
    else $error("st_ready high with a full queue");

  a_align: assert property (@(posedge clk) disable iff (rst)
    st_valid |-> (st_size == `STQ_SZ_BYTE) ||
      (st_size == `STQ_SZ_HALF && !st_addr[0]) || (st_addr[1:0] == 2'b00))
    else $error("misaligned store address");

endmodule

bind stq_top tb_stq_asserts u_asserts (.*);

// File: tb_stq_top.sv
// testbench for stq_top; expects aligned accesses only, loads stall only in the back-pressure step
`timescale 1ns/1ps

`include "stq_consts.svh"

module tb_stq_top import stq_pkg::*; ();

  typedef enum int {OP_ST, OP_DATA, OP_LD, OP_DRAIN} op_e;
  typedef struct {
    op_e       op;
    stq_addr_t addr;
    stq_size_t size;
    stq_idx_t  idx;
    stq_data_t data;
    stq_fwd_e  exp_kind;
    stq_data_t exp_data;
    string     name;
  } row_t;

  localparam int RST_CYCLES = 16;

  logic clk, rst, st_valid, st_ready, upd_en, ld_valid, ld_ready;
  logic resp_valid, resp_ready, drain_valid, drain_ready;
  stq_addr_t st_addr, ld_addr, drain_addr;
  stq_size_t st_size, ld_size;
  stq_idx_t  upd_idx;
  stq_data_t upd_data, resp_data, drain_data;
  stq_fwd_e  resp_kind;
  stq_be_t   drain_be;

  row_t rows[$];
  int errors, checks, cycles, limit;
  logic [31:0] rng;

  // queue model
  logic      m_valid [`STQ_DEPTH];
  logic      m_dv    [`STQ_DEPTH];
  stq_addr_t m_addr  [`STQ_DEPTH];
  stq_be_t   m_be    [`STQ_DEPTH];
  stq_data_t m_data  [`STQ_DEPTH];
  int        m_head, m_tail, m_count;

  stq_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= limit) begin
      $display("timeout: no progress after %0d cycles", limit);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  function automatic void add_row(op_e op, stq_addr_t a, stq_size_t s, stq_idx_t i,
                                  stq_data_t d, string name);
    row_t r;
    r.op = op;
    r.addr = a;
    r.size = s;
    r.idx = i;
    r.data = d;
    r.name = name;
    rows.push_back(r);
  endfunction

  function automatic stq_be_t lanes_of(stq_addr_t a, stq_size_t s);
    if (s == `STQ_SZ_BYTE) return stq_be_t'(1) << a[1:0];
    if (s == `STQ_SZ_HALF) return stq_be_t'(3) << a[1:0];
    return '1;
  endfunction

  // youngest overlapping store decides the outcome
  function automatic void predict(stq_addr_t a, stq_size_t s, output stq_fwd_e k,
                                  output stq_data_t d);
    stq_be_t be;
    int i;
    logic found;
    be = lanes_of(a, s);
    k = FWD_MISS;
    d = '0;
    found = 1'b0;
    for (int j = 1; j <= `STQ_DEPTH; j++) begin
      i = (m_tail - j) & (`STQ_DEPTH - 1);
      if (!found && m_valid[i] && m_addr[i][31:2] == a[31:2] && |(m_be[i] & be)) begin
        found = 1'b1;
        if ((m_be[i] & be) == be && m_dv[i]) begin
          k = FWD_HIT;
          d = m_data[i] >> (8 * a[1:0]);
          if (s == `STQ_SZ_BYTE) d = d & 32'h0000_00ff;
          if (s == `STQ_SZ_HALF) d = d & 32'h0000_ffff;
        end else begin
          k = FWD_CONFLICT;
        end
      end
    end
  endfunction

  task automatic check_kind(string name, stq_fwd_e exp, stq_fwd_e act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %s: expected %s, actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_data(string name, stq_data_t exp, stq_data_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_addr(string name, stq_addr_t exp, stq_addr_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_be(string name, stq_be_t exp, stq_be_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // all tasks start and end just after a falling edge
  task automatic do_store(row_t r);
    st_valid = 1'b1;
    st_addr = r.addr;
    st_size = r.size;
    while (!st_ready) @(negedge clk);
    @(negedge clk);
    st_valid = 1'b0;
    m_valid[m_tail] = 1'b1;
    m_dv[m_tail] = 1'b0;
    m_addr[m_tail] = r.addr;
    m_be[m_tail] = lanes_of(r.addr, r.size);
    m_tail = (m_tail + 1) % `STQ_DEPTH;
    m_count++;
  endtask

  task automatic do_data(row_t r);
    upd_en = 1'b1;
    upd_idx = r.idx;
    upd_data = r.data;
    @(negedge clk);
    upd_en = 1'b0;
    if (m_valid[r.idx]) begin
      m_dv[r.idx] = 1'b1;
      m_data[r.idx] = r.data;
    end
  endtask

  task automatic do_load(inout row_t r);
    int lat;
    predict(r.addr, r.size, r.exp_kind, r.exp_data);
    ld_valid = 1'b1;
    ld_addr = r.addr;
    ld_size = r.size;
    while (!ld_ready) @(negedge clk);
    @(negedge clk);
    ld_valid = 1'b0;
    lat = 1; // decode edge already passed
    while (!resp_valid && lat < 10) begin
      @(negedge clk);
      lat++;
    end
    if (!resp_valid) begin
      errors++;
      $display("%s: no load response arrived", r.name);
    end else begin
      if (lat != 2) begin
        errors++;
        $display("%s: response came %0d cycles after acceptance instead of 2", r.name, lat);
      end
      check_kind({r.name, " kind"}, r.exp_kind, resp_kind);
      check_data({r.name, " data"}, r.exp_data, resp_data);
    end
  endtask

  task automatic do_drain(row_t r);
    int n;
    stq_addr_t a;
    n = 0;
    while (!drain_valid && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!drain_valid) begin
      errors++;
      $display("%s: drain never became valid", r.name);
    end else begin
      a = drain_addr;
      repeat (2) @(negedge clk); // held off by the cache
      check_flag({r.name, " held valid"}, 1'b1, drain_valid);
      check_addr({r.name, " held addr"}, a, drain_addr);
      check_addr({r.name, " addr"}, {m_addr[m_head][31:2], 2'b00}, drain_addr);
      check_be({r.name, " be"}, m_be[m_head], drain_be);
      check_data({r.name, " data"}, m_data[m_head], drain_data);
      drain_ready = 1'b1;
      @(negedge clk);
      drain_ready = 1'b0;
      m_valid[m_head] = 1'b0;
      m_head = (m_head + 1) % `STQ_DEPTH;
      m_count--;
    end
  endtask

  // four loads against a held response, then release
  task automatic stall_loads(stq_addr_t a0, stq_addr_t a1);
    stq_addr_t addrs[4];
    stq_fwd_e  ek[4];
    stq_data_t ed[4];
    int issued, got;
    logic acc, take;
    addrs = '{a0, a1, 32'h0000_7000, a0};
    for (int i = 0; i < 4; i++) predict(addrs[i], `STQ_SZ_WORD, ek[i], ed[i]);
    issued = 0;
    got = 0;
    resp_ready = 1'b0;
    ld_valid = 1'b1;
    ld_addr = addrs[0];
    ld_size = `STQ_SZ_WORD;
    for (int n = 0; got < 4 && n < 40; n++) begin
      #1;
      if (n == 5) begin
        check_flag("stall ld_ready", 1'b0, ld_ready);
        check_flag("stall resp_valid", 1'b1, resp_valid);
      end
      acc = ld_valid && ld_ready;
      take = resp_valid && resp_ready;
      if (take) begin
        check_kind($sformatf("stall resp %0d kind", got), ek[got], resp_kind);
        check_data($sformatf("stall resp %0d data", got), ed[got], resp_data);
        got++;
      end
      @(negedge clk);
      if (acc) begin
        issued++;
        if (issued < 4) ld_addr = addrs[issued];
        else ld_valid = 1'b0;
      end
      if (n == 5) resp_ready = 1'b1;
    end
    if (got != 4) begin
      errors++;
      $display("stall: only %0d of 4 responses came back", got);
    end
    ld_valid = 1'b0;
    resp_ready = 1'b1;
  endtask

  task automatic build_table(output stq_addr_t ra[16]);
    add_row(OP_ST, 32'h100, `STQ_SZ_WORD, 0, 0, "word store");
    add_row(OP_DATA, 0, 0, 0, next_rand(), "data e0");
    add_row(OP_LD, 32'h102, `STQ_SZ_BYTE, 0, 0, "byte fwd");
    add_row(OP_LD, 32'h200, `STQ_SZ_WORD, 0, 0, "miss");
    add_row(OP_ST, 32'h200, `STQ_SZ_WORD, 0, 0, "store no data");
    add_row(OP_LD, 32'h200, `STQ_SZ_WORD, 0, 0, "data missing");
    add_row(OP_ST, 32'h301, `STQ_SZ_BYTE, 0, 0, "byte store");
    add_row(OP_DATA, 0, 0, 2, next_rand(), "data e2");
    add_row(OP_LD, 32'h300, `STQ_SZ_WORD, 0, 0, "partial cover");
    add_row(OP_ST, 32'h102, `STQ_SZ_HALF, 0, 0, "younger half");
    add_row(OP_DATA, 0, 0, 3, next_rand(), "data e3");
    add_row(OP_LD, 32'h102, `STQ_SZ_HALF, 0, 0, "youngest wins");
    add_row(OP_LD, 32'h101, `STQ_SZ_BYTE, 0, 0, "older lane");
    add_row(OP_DRAIN, 0, 0, 0, 0, "drain e0");
    add_row(OP_DATA, 0, 0, 1, next_rand(), "data e1");
    for (int i = 1; i < 4; i++) add_row(OP_DRAIN, 0, 0, 0, 0, $sformatf("drain e%0d", i));
    for (int i = 0; i < 16; i++) begin
      ra[i] = 32'h1000 | ((next_rand() & 32'hff) << 2);
      add_row(OP_ST, ra[i], `STQ_SZ_WORD, 0, 0, $sformatf("fill %0d", i));
    end
    add_row(OP_LD, ra[0], `STQ_SZ_WORD, 0, 0, "full queue load");
    add_row(OP_DATA, 0, 0, 4, next_rand(), "data e4");
    add_row(OP_DRAIN, 0, 0, 0, 0, "drain when full");
    add_row(OP_DATA, 0, 0, 5, next_rand(), "data e5");
  endtask

  initial begin
    stq_addr_t ra[16];
    int e0;
    rng = 32444;
    errors = 0;
    checks = 0;
    cycles = 0;
    limit = 1000;
    {rst, st_valid, upd_en, ld_valid, drain_ready} = 5'b10000;
    resp_ready = 1'b1;
    st_addr = '0;
    st_size = '0;
    ld_addr = '0;
    ld_size = '0;
    upd_idx = '0;
    upd_data = '0;
    m_head = 0;
    m_tail = 0;
    m_count = 0;
    for (int i = 0; i < `STQ_DEPTH; i++) {m_valid[i], m_dv[i]} = 2'b00;
    build_table(ra);
    limit = (rows.size() + 1) * 20 + RST_CYCLES; // stall step counts as one row
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    foreach (rows[r]) begin
      e0 = errors;
      case (rows[r].op)
        OP_ST:    do_store(rows[r]);
        OP_DATA:  do_data(rows[r]);
        OP_LD:    do_load(rows[r]);
        default:  do_drain(rows[r]);
      endcase
      check_flag({rows[r].name, " st_ready"}, m_count != `STQ_DEPTH, st_ready);
      check_flag({rows[r].name, " drain_valid"}, m_valid[m_head] && m_dv[m_head], drain_valid);
      $display("row %0d %s: %s", r, rows[r].name, errors == e0 ? "pass" : "FAIL");
    end
    e0 = errors;
    stall_loads(ra[1], ra[2]);
    $display("row %0d back-pressure: %s", rows.size(), errors == e0 ? "pass" : "FAIL");
    $display("rows %0d, checks %0d, errors %0d", rows.size() + 1, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: stq_top.f
+incdir+.
stq_pkg.sv
stq_if.sv
stq_decode.sv
stq_execute.sv
stq_result.sv
stq_top.sv
tb_stq_asserts.sv
tb_stq_top.sv

// File: Bender.yml
package:
  name: stq

sources:
  - include_dirs:
      - .
    files:
      - stq_pkg.sv
      - stq_if.sv
      - stq_decode.sv
      - stq_execute.sv
      - stq_result.sv
      - stq_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_stq_asserts.sv
      - tb_stq_top.sv
